// ==== dcache_settings.svh ====
// data cache geometry shared by the packages and the RTL
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// associativity fixed by the 3-bit tree LRU
`define DC_NUM_WAY 4

// sets per way
`define DC_NUM_SET 32

// stored tag width
`define DC_TAG_BITS 8

// one line of data
`define DC_DATA_BITS 64

`endif

// ==== cache_addr_pkg.sv ====
// address field types for the data cache lookup
`include "dcache_settings.svh"

package cache_addr_pkg;

  // tag compared against the stored line
  typedef logic [`DC_TAG_BITS-1:0] tag_t;

  // selects one set in every way
  typedef logic [$clog2(`DC_NUM_SET)-1:0] set_index_t;

  // way number for victim choice
  typedef logic [$clog2(`DC_NUM_WAY)-1:0] way_index_t;

endpackage

// ==== cache_line_pkg.sv ====
// stored cache line layout and line data type
`include "dcache_settings.svh"

package cache_line_pkg;

  typedef logic [`DC_DATA_BITS-1:0] data_t;

  // one entry of a way in 74 bits
  typedef struct packed {
    logic                  valid;
    logic                  dirty;
    cache_addr_pkg::tag_t  tag;
    data_t                 data;
  } line_t;

endpackage

// ==== cache_way.sv ====
// single cache way with read lookup, write lookup, line write and victim readout
`timescale 1ns/1ps
`include "dcache_settings.svh"

module cache_way (
  input  logic                       clock,
  input  logic                       reset,
  input  cache_addr_pkg::set_index_t rd_index,
  input  cache_addr_pkg::tag_t       rd_tag,
  input  cache_addr_pkg::set_index_t wr_index,
  input  cache_addr_pkg::tag_t       wr_tag,
  input  logic                       write,
  input  cache_line_pkg::data_t      wr_data,
  input  logic                       wr_dirty,
  input  logic                       wr_valid,
  output logic                       rd_hit,
  output cache_line_pkg::data_t      rd_data,
  output logic                       wr_hit,
  output logic                       evict_valid,
  output logic                       evict_dirty,
  output cache_addr_pkg::tag_t       evict_tag,
  output cache_line_pkg::data_t      evict_data
);

  cache_line_pkg::line_t lines [`DC_NUM_SET];
  cache_line_pkg::line_t rd_line;
  cache_line_pkg::line_t wr_line;

  assign rd_line = lines[rd_index];
  assign wr_line = lines[wr_index];

  // read port lookup
  assign rd_hit  = rd_line.valid && (rd_line.tag == rd_tag);
  assign rd_data = rd_line.data;

  // write port lookup and victim view of the same set
  assign wr_hit      = wr_line.valid && (wr_line.tag == wr_tag);
  assign evict_valid = wr_line.valid;
  assign evict_dirty = wr_line.dirty;
  assign evict_tag   = wr_line.tag;
  assign evict_data  = wr_line.data;

  always_ff @(posedge clock) begin
    if (reset) begin
      // clear the status bits of every set
      for (int s = 0; s < `DC_NUM_SET; s++) begin
        lines[s].valid <= 1'b0;
        lines[s].dirty <= 1'b0;
      end
    end else if (write) begin
      lines[wr_index] <= '{
        valid: wr_valid,
        dirty: wr_dirty,
        tag:   wr_tag,
        data:  wr_data
      };
    end
  end

endmodule

// ==== plru_tree.sv ====
// per-set tree pseudo-LRU for four ways with victim choice and update
`timescale 1ns/1ps
`include "dcache_settings.svh"

module plru_tree (
  input  logic                       clock,
  input  logic                       reset,
  input  cache_addr_pkg::set_index_t index,
  input  logic                       lru_update,
  output cache_addr_pkg::way_index_t victim_way
);

  // root picks the half and left or right the way inside it
  logic [`DC_NUM_SET-1:0] root_bits;
  logic [`DC_NUM_SET-1:0] left_bits;
  logic [`DC_NUM_SET-1:0] right_bits;

  logic                   root_bit;
  logic                   left_bit;
  logic                   right_bit;
  logic [`DC_NUM_WAY-1:0] choice;

  assign root_bit  = root_bits[index];
  assign left_bit  = left_bits[index];
  assign right_bit = right_bits[index];

  // one-hot victim from the tree walk
  assign choice[0] = ~root_bit & ~left_bit;
  assign choice[1] = ~root_bit &  left_bit;
  assign choice[2] =  root_bit & ~right_bit;
  assign choice[3] =  root_bit &  right_bit;

  // priority encode with the lowest way first
  always_comb begin
    victim_way = '0;
    for (int w = `DC_NUM_WAY - 1; w >= 0; w--) begin
      if (choice[w]) begin
        victim_way = cache_addr_pkg::way_index_t'(w);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      root_bits  <= '0;
      left_bits  <= '0;
      right_bits <= '0;
    end else if (lru_update) begin
      root_bits[index] <= ~root_bit;
      // flip the half that was just filled
      if (root_bit) begin
        right_bits[index] <= ~right_bit;
      end else begin
        left_bits[index] <= ~left_bit;
      end
    end
  end

endmodule

// ==== way_combine.sv ====
// merges per-way lookups, steers the write strobe and selects the eviction line
`timescale 1ns/1ps
`include "dcache_settings.svh"

module way_combine (
  input  logic                                          wr_en,
  input  logic                                          wr_fill,
  input  logic                  [`DC_NUM_WAY-1:0]       way_rd_hit,
  input  logic                  [`DC_NUM_WAY-1:0]       way_wr_hit,
  input  cache_line_pkg::data_t [`DC_NUM_WAY-1:0]       way_rd_data,
  input  cache_line_pkg::data_t [`DC_NUM_WAY-1:0]       way_evict_data,
  input  logic                  [`DC_NUM_WAY-1:0]       way_evict_valid,
  input  logic                  [`DC_NUM_WAY-1:0]       way_evict_dirty,
  input  cache_addr_pkg::tag_t  [`DC_NUM_WAY-1:0]       way_evict_tag,
  input  cache_addr_pkg::way_index_t                    victim_way,
  output logic                                          rd_hit,
  output cache_line_pkg::data_t                         rd_data,
  output logic                                          wr_hit,
  output logic                  [`DC_NUM_WAY-1:0]       way_write,
  output logic                                          lru_update,
  output logic                                          evict_valid,
  output logic                                          evict_dirty,
  output cache_addr_pkg::tag_t                          evict_tag,
  output cache_line_pkg::data_t                         evict_data
);

  logic                   fill_miss;
  logic [`DC_NUM_WAY-1:0] victim_onehot;

  assign rd_hit = |way_rd_hit;
  assign wr_hit = |way_wr_hit;

  // data of the single hitting way
  always_comb begin
    rd_data = '0;
    for (int w = 0; w < `DC_NUM_WAY; w++) begin
      if (way_rd_hit[w]) begin
        rd_data = way_rd_data[w];
      end
    end
  end

  always_comb begin
    victim_onehot             = '0;
    victim_onehot[victim_way] = 1'b1;
  end

  // fill from memory into a set that lacks the tag
  assign fill_miss  = wr_en & wr_fill & ~wr_hit;
  assign lru_update = fill_miss;

  // hit way first and then the LRU victim
  always_comb begin
    if (wr_en && wr_hit) begin
      way_write = way_wr_hit;
    end else if (fill_miss) begin
      way_write = victim_onehot;
    end else begin
      way_write = '0;
    end
  end

  // line that a fill would replace
  assign evict_valid = way_evict_valid[victim_way];
  assign evict_dirty = way_evict_dirty[victim_way];
  assign evict_tag   = way_evict_tag[victim_way];
  assign evict_data  = way_evict_data[victim_way];

endmodule

// ==== dcache_top.sv ====
// four-way set-associative data cache storage with tree pseudo-LRU
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top (
  input  logic                       clock,
  input  logic                       reset,
  input  cache_addr_pkg::tag_t       rd_tag,
  input  cache_addr_pkg::set_index_t rd_index,
  input  logic                       wr_en,
  input  logic                       wr_fill,
  input  cache_addr_pkg::tag_t       wr_tag,
  input  cache_addr_pkg::set_index_t wr_index,
  input  cache_line_pkg::data_t      wr_data,
  input  logic                       wr_dirty,
  input  logic                       wr_valid,
  output logic                       rd_hit,
  output cache_line_pkg::data_t      rd_data,
  output logic                       wr_hit,
  output logic                       evict_valid,
  output logic                       evict_dirty,
  output cache_addr_pkg::tag_t       evict_tag,
  output cache_line_pkg::data_t      evict_data
);

  logic                  [`DC_NUM_WAY-1:0] way_rd_hit;
  logic                  [`DC_NUM_WAY-1:0] way_wr_hit;
  logic                  [`DC_NUM_WAY-1:0] way_write;
  cache_line_pkg::data_t [`DC_NUM_WAY-1:0] way_rd_data;
  cache_line_pkg::data_t [`DC_NUM_WAY-1:0] way_evict_data;
  logic                  [`DC_NUM_WAY-1:0] way_evict_valid;
  logic                  [`DC_NUM_WAY-1:0] way_evict_dirty;
  cache_addr_pkg::tag_t  [`DC_NUM_WAY-1:0] way_evict_tag;
  cache_addr_pkg::way_index_t              victim_way;
  logic                                    lru_update;

  for (genvar w = 0; w < `DC_NUM_WAY; w++) begin : g_way
    cache_way way_i (
      .clock       (clock),
      .reset       (reset),
      .rd_index    (rd_index),
      .rd_tag      (rd_tag),
      .wr_index    (wr_index),
      .wr_tag      (wr_tag),
      .write       (way_write[w]),
      .wr_data     (wr_data),
      .wr_dirty    (wr_dirty),
      .wr_valid    (wr_valid),
      .rd_hit      (way_rd_hit[w]),
      .rd_data     (way_rd_data[w]),
      .wr_hit      (way_wr_hit[w]),
      .evict_valid (way_evict_valid[w]),
      .evict_dirty (way_evict_dirty[w]),
      .evict_tag   (way_evict_tag[w]),
      .evict_data  (way_evict_data[w])
    );
  end

  // LRU state follows the write index
  plru_tree lru_i (
    .clock      (clock),
    .reset      (reset),
    .index      (wr_index),
    .lru_update (lru_update),
    .victim_way (victim_way)
  );

  way_combine combine_i (
    .wr_en           (wr_en),
    .wr_fill         (wr_fill),
    .way_rd_hit      (way_rd_hit),
    .way_wr_hit      (way_wr_hit),
    .way_rd_data     (way_rd_data),
    .way_evict_data  (way_evict_data),
    .way_evict_valid (way_evict_valid),
    .way_evict_dirty (way_evict_dirty),
    .way_evict_tag   (way_evict_tag),
    .victim_way      (victim_way),
    .rd_hit          (rd_hit),
    .rd_data         (rd_data),
    .wr_hit          (wr_hit),
    .way_write       (way_write),
    .lru_update      (lru_update),
    .evict_valid     (evict_valid),
    .evict_dirty     (evict_dirty),
    .evict_tag       (evict_tag),
    .evict_data      (evict_data)
  );

endmodule

// ==== dcache_tb.sv ====
// testbench that checks each table row of the data cache storage against a reference model
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb;

  localparam logic [1:0] op_read  = 2'd0;
  localparam logic [1:0] op_store = 2'd1;
  localparam logic [1:0] op_fill  = 2'd2;

  typedef struct packed {
    logic [1:0]                 op;
    cache_addr_pkg::tag_t       tag;
    cache_addr_pkg::set_index_t index;
    cache_line_pkg::data_t      data;
    logic                       dirty;
    logic                       valid;
    cache_addr_pkg::tag_t       read_tag;
    cache_addr_pkg::set_index_t read_index;
    logic                       exp_rd_hit;
    cache_line_pkg::data_t      exp_rd_data;
    logic                       exp_wr_hit;
    logic                       exp_ev_valid;
    logic                       exp_ev_dirty;
    cache_addr_pkg::tag_t       exp_ev_tag;
    cache_line_pkg::data_t      exp_ev_data;
  } row_t;

  logic                       clock;
  logic                       reset;
  cache_addr_pkg::tag_t       rd_tag;
  cache_addr_pkg::set_index_t rd_index;
  logic                       wr_en;
  logic                       wr_fill;
  cache_addr_pkg::tag_t       wr_tag;
  cache_addr_pkg::set_index_t wr_index;
  cache_line_pkg::data_t      wr_data;
  logic                       wr_dirty;
  logic                       wr_valid;
  logic                       rd_hit;
  cache_line_pkg::data_t      rd_data;
  logic                       wr_hit;
  logic                       evict_valid;
  logic                       evict_dirty;
  cache_addr_pkg::tag_t       evict_tag;
  cache_line_pkg::data_t      evict_data;

  // reference model state
  logic                  m_valid [`DC_NUM_WAY][`DC_NUM_SET];
  logic                  m_dirty [`DC_NUM_WAY][`DC_NUM_SET];
  cache_addr_pkg::tag_t  m_tag   [`DC_NUM_WAY][`DC_NUM_SET];
  cache_line_pkg::data_t m_data  [`DC_NUM_WAY][`DC_NUM_SET];
  logic                  lru_root  [`DC_NUM_SET];
  logic                  lru_left  [`DC_NUM_SET];
  logic                  lru_right [`DC_NUM_SET];

  // address of the previous row
  cache_addr_pkg::tag_t       prev_tag;
  cache_addr_pkg::set_index_t prev_index;

  row_t rows [$];
  int   check_count;
  int   error_count;
  int   watchdog_ns;
  bit   table_ready;

  dcache_top dut_i (
    .clock       (clock),
    .reset       (reset),
    .rd_tag      (rd_tag),
    .rd_index    (rd_index),
    .wr_en       (wr_en),
    .wr_fill     (wr_fill),
    .wr_tag      (wr_tag),
    .wr_index    (wr_index),
    .wr_data     (wr_data),
    .wr_dirty    (wr_dirty),
    .wr_valid    (wr_valid),
    .rd_hit      (rd_hit),
    .rd_data     (rd_data),
    .wr_hit      (wr_hit),
    .evict_valid (evict_valid),
    .evict_dirty (evict_dirty),
    .evict_tag   (evict_tag),
    .evict_data  (evict_data)
  );

  always #2 clock = ~clock;

  function automatic string op_name(input logic [1:0] op);
    case (op)
      op_store: return "store";
      op_fill:  return "fill ";
      default:  return "read ";
    endcase
  endfunction

  // root picks the half and left or right picks the way inside it
  function automatic int predict_victim(input int s);
    if (!lru_root[s]) begin
      return lru_left[s] ? 1 : 0;
    end
    return lru_right[s] ? 3 : 2;
  endfunction

  // way that holds a valid copy of the tag, or -1
  function automatic int find_way(input int s, input cache_addr_pkg::tag_t tag);
    int found;
    found = -1;
    for (int w = 0; w < `DC_NUM_WAY; w++) begin
      if (m_valid[w][s] && m_tag[w][s] == tag) begin
        found = w;
      end
    end
    return found;
  endfunction

  task automatic init_model();
    for (int s = 0; s < `DC_NUM_SET; s++) begin
      for (int w = 0; w < `DC_NUM_WAY; w++) begin
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
        m_tag[w][s]   = '0;
        m_data[w][s]  = '0;
      end
      lru_root[s]  = 1'b0;
      lru_left[s]  = 1'b0;
      lru_right[s] = 1'b0;
    end
    prev_tag   = '0;
    prev_index = '0;
  endtask

  // predicts all outputs for one row and then applies it to the model
  // a write row points the read port at the previous row's address
  task automatic add_row(input logic [1:0] op, input cache_addr_pkg::tag_t tag,
                         input cache_addr_pkg::set_index_t index,
                         input cache_line_pkg::data_t data, input logic dirty,
                         input logic valid = 1'b1);
    row_t r;
    int   s;
    int   rs;
    int   hit_way;
    int   rd_way;
    int   vic;
    s            = int'(index);
    hit_way      = find_way(s, tag);
    vic          = predict_victim(s);
    r.read_tag   = (op == op_read) ? tag : prev_tag;
    r.read_index = (op == op_read) ? index : prev_index;
    rs           = int'(r.read_index);
    rd_way       = find_way(rs, r.read_tag);
    r.op           = op;
    r.tag          = tag;
    r.index        = index;
    r.data         = data;
    r.dirty        = dirty;
    r.valid        = valid;
    r.exp_rd_hit   = (rd_way >= 0);
    r.exp_rd_data  = (rd_way >= 0) ? m_data[rd_way][rs] : '0;
    r.exp_wr_hit   = (hit_way >= 0);
    r.exp_ev_valid = m_valid[vic][s];
    r.exp_ev_dirty = m_dirty[vic][s];
    r.exp_ev_tag   = m_tag[vic][s];
    r.exp_ev_data  = m_data[vic][s];
    if (op != op_read) begin
      if (hit_way >= 0) begin
        m_valid[hit_way][s] = valid;
        m_dirty[hit_way][s] = dirty;
        m_tag[hit_way][s]   = tag;
        m_data[hit_way][s]  = data;
      end else if (op == op_fill) begin
        m_valid[vic][s] = valid;
        m_dirty[vic][s] = dirty;
        m_tag[vic][s]   = tag;
        m_data[vic][s]  = data;
        lru_root[s]     = ~lru_root[s];
        // the half that was just filled flips
        if (vic < 2) begin
          lru_left[s] = ~lru_left[s];
        end else begin
          lru_right[s] = ~lru_right[s];
        end
      end
    end
    prev_tag   = tag;
    prev_index = index;
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [1:0]                 pick_op;
    cache_addr_pkg::set_index_t pick_set;
    // empty cache after reset misses in every set
    for (int k = 0; k < `DC_NUM_SET; k++) begin
      add_row(op_read, cache_addr_pkg::tag_t'(8'h11 + k),
              cache_addr_pkg::set_index_t'(k), '0, 1'b0);
    end
    // fill then read and a store miss that leaves no line
    add_row(op_fill, 8'h11, 5'd3, 64'h0123_4567_89ab_cdef, 1'b0);
    add_row(op_read, 8'h11, 5'd3, '0, 1'b0);
    add_row(op_store, 8'h22, 5'd3, 64'hdead_beef_0000_0022, 1'b0);
    add_row(op_read, 8'h22, 5'd3, '0, 1'b0);
    // store hit marks the line dirty
    add_row(op_store, 8'h11, 5'd3, 64'hfeed_face_1111_0011, 1'b1);
    add_row(op_read, 8'h11, 5'd3, '0, 1'b0);
    // six fills in set 7 land in ways 0 2 1 3 0 2
    for (int k = 0; k < 6; k++) begin
      add_row(op_fill, cache_addr_pkg::tag_t'(8'h70 + k), 5'd7,
              64'h7070_0000_0000_0000 + 64'(k), 1'b0);
    end
    for (int k = 0; k < 6; k++) begin
      add_row(op_read, cache_addr_pkg::tag_t'(8'h70 + k), 5'd7, '0, 1'b0);
    end
    // fourth new fill in set 3 evicts the dirty line
    for (int k = 1; k < 5; k++) begin
      add_row(op_fill, cache_addr_pkg::tag_t'(8'h30 + k), 5'd3,
              64'h3030_0000_0000_0000 + 64'(k), 1'b0);
    end
    // other sets stay untouched
    add_row(op_read, 8'hc0, 5'd12, '0, 1'b0);
    add_row(op_fill, 8'hc0, 5'd12, 64'hc0c0_c0c0_0000_000c, 1'b0);
    add_row(op_store, 8'hc0, 5'd12, 64'hc0c0_c0c0_1111_000c, 1'b1);
    add_row(op_read, 8'h72, 5'd7, '0, 1'b0);
    add_row(op_read, 8'h32, 5'd3, '0, 1'b0);
    add_row(op_read, 8'hc0, 5'd13, '0, 1'b0);
    add_row(op_read, 8'h70, 5'd7, '0, 1'b0);
    // store hit with valid low drops the line
    add_row(op_store, 8'hc0, 5'd12, '0, 1'b0, 1'b0);
    add_row(op_read, 8'hc0, 5'd12, '0, 1'b0);
    // random mix over three sets with a small tag pool
    for (int k = 0; k < 40; k++) begin
      pick_op = 2'($urandom % 3);
      case ($urandom % 3)
        0:       pick_set = 5'd5;
        1:       pick_set = 5'd6;
        default: pick_set = 5'd20;
      endcase
      add_row(pick_op, cache_addr_pkg::tag_t'(8'h40 + ($urandom % 6)), pick_set,
              {$urandom, $urandom}, 1'($urandom % 2), ($urandom % 8) != 0);
    end
  endtask

  task automatic drive_row(input row_t r);
    rd_tag   = r.read_tag;
    rd_index = r.read_index;
    wr_tag   = r.tag;
    wr_index = r.index;
    wr_data  = r.data;
    wr_dirty = r.dirty;
    wr_valid = r.valid;
    wr_en    = (r.op != op_read);
    wr_fill  = (r.op == op_fill);
  endtask

  task automatic check_row(input int i, input row_t r);
    int row_errors;
    row_errors = 0;
    check_count++;
    if (rd_hit !== r.exp_rd_hit) begin
      $display("ERROR row %0d rd_hit got %h expected %h", i, rd_hit, r.exp_rd_hit);
      row_errors++;
    end
    if (r.exp_rd_hit && rd_data !== r.exp_rd_data) begin
      $display("ERROR row %0d rd_data got %h expected %h", i, rd_data, r.exp_rd_data);
      row_errors++;
    end
    if (wr_hit !== r.exp_wr_hit) begin
      $display("ERROR row %0d wr_hit got %h expected %h", i, wr_hit, r.exp_wr_hit);
      row_errors++;
    end
    if (evict_valid !== r.exp_ev_valid) begin
      $display("ERROR row %0d evict_valid got %h expected %h", i, evict_valid,
               r.exp_ev_valid);
      row_errors++;
    end
    if (evict_dirty !== r.exp_ev_dirty) begin
      $display("ERROR row %0d evict_dirty got %h expected %h", i, evict_dirty,
               r.exp_ev_dirty);
      row_errors++;
    end
    // tag and data of an invalid line are stale
    if (r.exp_ev_valid && evict_tag !== r.exp_ev_tag) begin
      $display("ERROR row %0d evict_tag got %h expected %h", i, evict_tag, r.exp_ev_tag);
      row_errors++;
    end
    if (r.exp_ev_valid && evict_data !== r.exp_ev_data) begin
      $display("ERROR row %0d evict_data got %h expected %h", i, evict_data,
               r.exp_ev_data);
      row_errors++;
    end
    error_count += row_errors;
    $display("row %0d %s tag %h set %0d : %s", i, op_name(r.op), r.tag, r.index,
             (row_errors == 0) ? "ok" : "mismatch");
  endtask

  initial begin
    void'($urandom(32'hb150));
    clock    = 1'b0;
    reset    = 1'b1;
    rd_tag   = '0;
    rd_index = '0;
    wr_en    = 1'b0;
    wr_fill  = 1'b0;
    wr_tag   = '0;
    wr_index = '0;
    wr_data  = '0;
    wr_dirty = 1'b0;
    wr_valid = 1'b0;
    init_model();
    build_table();
    watchdog_ns = rows.size() * 4 * 4 + 2 * 4;
    table_ready = 1'b1;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clock);
      #1;
      drive_row(rows[i]);
      // outputs settle well before the next edge
      #2;
      check_row(i, rows[i]);
    end
    @(posedge clock);
    #1;
    wr_en   = 1'b0;
    wr_fill = 1'b0;
    $display("rows %0d checks %0d errors %0d", rows.size(), check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the row loop did not finish", watchdog_ns);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
cache_addr_pkg.sv
cache_line_pkg.sv
cache_way.sv
plru_tree.sv
way_combine.sv
dcache_top.sv
dcache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the data cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module dcache_tb -o dcache_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log

grep -F -q "*** TEST PASSED ***" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
